/* all.f */
+incdir+.
rhythm_pkg.sv
key_decoder.sv
page_menu.sv
chart_storage.sv
menu_top.sv
menu_checker.sv
tb_menu.sv

/* chart_storage.sv */
`timescale 1ns/1ps
`include "rhythm_config.svh"

module chart_storage (
    input  logic                  clk,
    input  logic                  rst,
    input  rhythm_pkg::chart_id_t read_chart_id,
    output rhythm_pkg::note_t [`CHART_LEN-1:0] chart_notes
);
    import rhythm_pkg::*;

    note_t [`CHART_LEN-1:0] rom [`CHART_COUNT];

    // Free Play is empty, other charts hold (3c + s) mod 16.
    for (genvar c = 0; c < `CHART_COUNT; c++) begin : g_chart
        for (genvar s = 0; s < `CHART_LEN; s++) begin : g_step
            if (c == 0) begin : g_free
                assign rom[c][s] = '0;
            end else begin : g_song
                assign rom[c][s] = note_t'((3 * c + s) % 16);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            chart_notes <= rom[0];
        end else begin
            chart_notes <= rom[read_chart_id];
        end
    end

    a_addr_range: assert property (@(posedge clk) disable iff (rst)
        read_chart_id < chart_id_t'(`CHART_COUNT));

endmodule

/* key_decoder.sv */
`timescale 1ns/1ps
`include "rhythm_config.svh"

module key_decoder (
    input  logic clk,
    input  logic rst,
    input  logic key_up,
    input  logic key_down,
    input  logic key_left,
    input  logic key_right,
    output logic up_press,
    output logic down_press,
    output logic left_press,
    output logic right_press
);
    import rhythm_pkg::*;

    logic [3:0] keys;
    logic [3:0] key_prev;
    logic [3:0] rise;
    key_ev_t    evt;

    assign keys = {key_up, key_down, key_left, key_right};
    assign rise = keys & ~key_prev;

    // Up wins over down, down over left, left over right.
    always_comb begin
        evt = KEY_NONE;
        if (rise[3]) begin
            evt = KEY_UP;
        end else if (rise[2]) begin
            evt = KEY_DOWN;
        end else if (rise[1]) begin
            evt = KEY_LEFT;
        end else if (rise[0]) begin
            evt = KEY_RIGHT;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_prev    <= '0;
            up_press    <= 1'b0;
            down_press  <= 1'b0;
            left_press  <= 1'b0;
            right_press <= 1'b0;
        end else begin
            key_prev    <= keys;
            up_press    <= (evt == KEY_UP);
            down_press  <= (evt == KEY_DOWN);
            left_press  <= (evt == KEY_LEFT);
            right_press <= (evt == KEY_RIGHT);
        end
    end

    a_one_press: assert property (@(posedge clk) disable iff (rst)
        $onehot0({up_press, down_press, left_press, right_press}));

endmodule

/* menu_checker.sv */
`timescale 1ns/1ps
`include "rhythm_config.svh"

module menu_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  key_up,
    input  logic                  key_down,
    input  logic                  key_left,
    input  logic                  key_right,
    input  logic [3:0]            row_sel,
    input  rhythm_pkg::text_row_t row_text,
    input  rhythm_pkg::chart_id_t read_chart_id,
    input  rhythm_pkg::note_t [`CHART_LEN-1:0] chart_notes,
    input  logic                  auto_play,
    input  logic                  play_start,
    input  logic                  test_done,
    input  int                    test_num,
    input  int                    file_cursor,
    output int                    pass_count,
    output int                    fail_count
);
    import rhythm_pkg::*;

    localparam text_row_t ROW0   = "=========  Main Menu  ==========";
    localparam text_row_t ROW2   = "---------  Chart List  ---------";
    localparam text_row_t SPACES = {`ROW_CHARS{8'h20}};
    localparam int        TOP    = `ROW_CHARS * 8 - 1;

    cursor_t    m_cursor;
    logic       m_auto;
    logic [3:0] m_prev;
    logic [3:0] rise;
    int         since_evt;
    int         plays;
    int         exp_plays;
    int         test_err;

    // Empty for chart 0, else (3c + s) mod 16 at step s.
    function automatic logic [`CHART_LEN*4-1:0] chart_image(input int c);
        logic [`CHART_LEN*4-1:0] img;
        for (int s = 0; s < `CHART_LEN; s++) begin
            img[s*4 +: 4] = (c == 0) ? 4'h0 : 4'((3 * c + s) % 16);
        end
        return img;
    endfunction

    task automatic mismatch(input string name, input logic [255:0] exp, input logic [255:0] got);
        $display("MISMATCH %s: expected %0h, got %0h", name, exp, got);
        test_err++;
    endtask

    task automatic compare_outputs();
        int          exp_id;
        int          mark;
        logic [23:0] exp_mark;
        exp_id = (m_cursor == 0) ? 0 : int'(m_cursor) - 1;
        mark   = (m_cursor == 0) ? 1 : int'(m_cursor) + 2;
        if (read_chart_id !== 3'(exp_id)) mismatch("read_chart_id", exp_id, read_chart_id);
        if (chart_notes !== chart_image(exp_id)) begin
            mismatch("chart_notes", chart_image(exp_id), chart_notes);
        end
        if (auto_play !== m_auto) mismatch("auto_play", m_auto, auto_play);
        if (row_sel >= `TEXT_ROWS && row_text !== SPACES) mismatch("row_text", SPACES, row_text);
        if (row_sel == 0 && row_text !== ROW0) mismatch("row_text[0]", ROW0, row_text);
        if (row_sel == 2 && row_text !== ROW2) mismatch("row_text[2]", ROW2, row_text);
        if (row_sel == 1 || (row_sel >= 3 && row_sel <= 7)) begin
            exp_mark = (row_sel == mark) ? ">>>" : "   ";
            if (row_text[TOP -: 24] !== exp_mark) begin
                mismatch($sformatf("row_text[%0d] marker", row_sel), exp_mark,
                         row_text[TOP -: 24]);
            end
        end
    endtask

    task automatic finish_test();
        if (file_cursor >= 0 && file_cursor != int'(m_cursor)) begin
            $display("Test %0d: stim file expects cursor %0d but the key rules give %0d",
                     test_num, file_cursor, m_cursor);
            test_err++;
        end
        if (since_evt < 3) begin
            $display("Test %0d: outputs had not settled when the test ended", test_num);
            test_err++;
        end
        if (plays != exp_plays) mismatch("play_start pulse count", exp_plays, plays);
        if (test_err == 0) begin
            $display("Test %0d: pass", test_num);
            pass_count++;
        end else begin
            $display("Test %0d: FAIL with %0d errors", test_num, test_err);
            fail_count++;
        end
        test_err  = 0;
        plays     = 0;
        exp_plays = 0;
    endtask

    // Outputs are compared once the last press has reached chart_notes.
    always @(posedge clk) begin
        if (rst) begin
            m_cursor   = '0;
            m_auto     = 1'b0;
            m_prev     = 4'b0000;
            since_evt  = 3;
            plays      = 0;
            exp_plays  = 0;
            test_err   = 0;
            pass_count = 0;
            fail_count = 0;
        end else begin
            if (since_evt >= 3) compare_outputs();
            if (play_start) plays++;
            if (test_done) finish_test();
            rise   = {key_up, key_down, key_left, key_right} & ~m_prev;
            m_prev = {key_up, key_down, key_left, key_right};
            since_evt = (rise != 0) ? 0 : ((since_evt < 3) ? since_evt + 1 : 3);
            // Up, down, left, right priority; the down wrap skips Score History.
            if (rise[3]) begin
                m_cursor = (m_cursor == 0) ? cursor_t'(`MENU_ENTRIES - 1) : m_cursor - 3'd1;
            end else if (rise[2]) begin
                m_cursor = (m_cursor == cursor_t'(`MENU_ENTRIES - 1)) ? 3'd1 : m_cursor + 3'd1;
            end else if (rise[1]) begin
                m_auto = 1'b1;
            end else if (rise[0] && m_cursor != 0) begin
                exp_plays++;
            end
        end
    end

endmodule

/* menu_stim.txt */
# key hold release cursor: keys joined by '+', hold and release in clock cycles
# rand draws key and hold from the LFSR; cursor is the expected position, -1 if unknown
none 2 4 0
down 1 4 1
down 1 4 2
down 2 4 3
down 1 4 4
down 1 4 5
down 1 4 1
up 1 4 0
up 1 4 5
down 6 4 1
up+down 2 4 0
right 1 4 0
left+right 1 4 0
down+left 1 4 1
right 3 4 1
rand 0 4 -1
rand 0 4 -1
rand 0 4 -1
rand 0 4 -1

/* menu_top.sv */
`timescale 1ns/1ps
`include "rhythm_config.svh"

module menu_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  key_up,
    input  logic                  key_down,
    input  logic                  key_left,
    input  logic                  key_right,
    input  logic [3:0]            row_sel,
    output rhythm_pkg::text_row_t row_text,
    output rhythm_pkg::chart_id_t read_chart_id,
    output rhythm_pkg::note_t [`CHART_LEN-1:0] chart_notes,
    output logic                  auto_play,
    output logic                  play_start
);
    logic up_press;
    logic down_press;
    logic left_press;
    logic right_press;

    key_decoder u_keys (
        .clk         (clk),
        .rst         (rst),
        .key_up      (key_up),
        .key_down    (key_down),
        .key_left    (key_left),
        .key_right   (key_right),
        .up_press    (up_press),
        .down_press  (down_press),
        .left_press  (left_press),
        .right_press (right_press)
    );

    page_menu u_menu (
        .clk           (clk),
        .rst           (rst),
        .up_press      (up_press),
        .down_press    (down_press),
        .left_press    (left_press),
        .right_press   (right_press),
        .row_sel       (row_sel),
        .row_text      (row_text),
        .read_chart_id (read_chart_id),
        .auto_play     (auto_play),
        .play_start    (play_start)
    );

    chart_storage u_charts (
        .clk           (clk),
        .rst           (rst),
        .read_chart_id (read_chart_id),
        .chart_notes   (chart_notes)
    );

endmodule

/* page_menu.sv */
`timescale 1ns/1ps
`include "rhythm_config.svh"

module page_menu (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  up_press,
    input  logic                  down_press,
    input  logic                  left_press,
    input  logic                  right_press,
    input  logic [3:0]            row_sel,
    output rhythm_pkg::text_row_t row_text,
    output rhythm_pkg::chart_id_t read_chart_id,
    output logic                  auto_play,
    output logic                  play_start
);
    import rhythm_pkg::*;

    localparam logic [23:0] MARKER = ">>>";
    localparam logic [23:0] BLANK  = "   ";

    cursor_t   cursor;
    cursor_t   cursor_next;
    text_row_t text [`TEXT_ROWS];

    // Pads a short literal with trailing spaces.
    function automatic text_row_t left_just(input text_row_t s);
        text_row_t r;
        r = s;
        for (int i = 0; i < `ROW_CHARS; i++) begin
            if (r[`ROW_CHARS*8-1 -: 8] == 8'h00) begin
                r = {r[`ROW_CHARS*8-9:0], 8'h20};
            end
        end
        return r;
    endfunction

    function automatic text_row_t base_row(input int row);
        text_row_t r;
        case (row)
            0:       r = left_just("=========  Main Menu  ==========");
            1:       r = left_just("    Score History");
            2:       r = left_just("---------  Chart List  ---------");
            3:       r = left_just("    [0]  Free Play");
            4:       r = left_just("    [1]  Tiny Stars");
            5:       r = left_just("    [2]  Song 1");
            6:       r = left_just("    [3]  Song 2");
            7:       r = left_just("    [4]  Recorded Song");
            9:       r = left_just("[^][v] Move Up / Down");
            10:      r = left_just("[<] Auto Play     [>] Play Chart");
            default: r = left_just(" ");
        endcase
        return r;
    endfunction

    // Cursor 0 points at row 1, cursor k at row k+2.
    function automatic text_row_t compose_row(input int row, input cursor_t cur);
        text_row_t r;
        int        mark;
        r    = base_row(row);
        mark = (cur == '0) ? 1 : int'(cur) + 2;
        if (row == 1 || (row >= 3 && row <= 7)) begin
            r[`ROW_CHARS*8-1 -: 24] = (row == mark) ? MARKER : BLANK;
        end
        return r;
    endfunction

    // Wrap skips Score History going down, reaches the last chart going up.
    always_comb begin
        cursor_next = cursor;
        if (up_press) begin
            if (cursor == '0) begin
                cursor_next = cursor_t'(`MENU_ENTRIES - 1);
            end else begin
                cursor_next = cursor - 3'd1;
            end
        end else if (down_press) begin
            if (cursor == cursor_t'(`MENU_ENTRIES - 1)) begin
                cursor_next = 3'd1;
            end else begin
                cursor_next = cursor + 3'd1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cursor        <= '0;
            read_chart_id <= '0;
            auto_play     <= 1'b0;
            play_start    <= 1'b0;
        end else begin
            cursor <= cursor_next;
            // Follows the cursor one cycle later.
            read_chart_id <= (cursor != '0) ? chart_id_t'(cursor - 3'd1) : '0;
            if (left_press) begin
                auto_play <= 1'b1;
            end
            play_start <= right_press && (cursor != '0);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < `TEXT_ROWS; r++) begin
                text[r] <= compose_row(r, '0);
            end
        end else begin
            for (int r = 0; r < `TEXT_ROWS; r++) begin
                text[r] <= compose_row(r, cursor_next);
            end
        end
    end

    always_comb begin
        if (row_sel < 4'(`TEXT_ROWS)) begin
            row_text = text[row_sel];
        end else begin
            row_text = {`ROW_CHARS{8'h20}};
        end
    end

    a_cursor_range: assert property (@(posedge clk) disable iff (rst)
        cursor < cursor_t'(`MENU_ENTRIES));

    // The chart ROM holds only CHART_COUNT entries.
    a_chart_id_range: assert property (@(posedge clk) disable iff (rst)
        read_chart_id < chart_id_t'(`CHART_COUNT));

endmodule

/* rhythm_config.svh */
`ifndef RHYTHM_CONFIG_SVH
`define RHYTHM_CONFIG_SVH

// Number of stored charts, chart 0 is Free Play.
`define CHART_COUNT 5

// Notes per chart preview.
`define CHART_LEN 16

// Cursor positions: Score History plus one per chart.
`define MENU_ENTRIES 6

// Screen text geometry.
`define TEXT_ROWS 11
`define ROW_CHARS 32

`endif

/* rhythm_pkg.sv */
`include "rhythm_config.svh"

package rhythm_pkg;

    // One bit per lane.
    typedef logic [3:0] note_t;

    // Character 0 sits in the most significant byte.
    typedef logic [`ROW_CHARS*8-1:0] text_row_t;

    typedef logic [2:0] chart_id_t;

    typedef logic [2:0] cursor_t;

    // Decoded key press after priority resolution.
    typedef enum logic [2:0] {
        KEY_NONE  = 3'd0,
        KEY_UP    = 3'd1,
        KEY_DOWN  = 3'd2,
        KEY_LEFT  = 3'd3,
        KEY_RIGHT = 3'd4
    } key_ev_t;

endpackage

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_menu -o tb_menu_sim
./obj_dir/tb_menu_sim > sim.log 2>&1
cat sim.log
if grep -qx "No errors" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi

/* tb_menu.sv */
`timescale 1ns/1ps
`include "rhythm_config.svh"

module tb_menu;
    import rhythm_pkg::*;

    logic                     clk;
    logic                     rst;
    logic                     key_up;
    logic                     key_down;
    logic                     key_left;
    logic                     key_right;
    logic [3:0]               row_sel;
    text_row_t                row_text;
    chart_id_t                read_chart_id;
    note_t [`CHART_LEN-1:0]   chart_notes;
    logic                     auto_play;
    logic                     play_start;
    logic                     test_done;
    int                       test_num;
    int                       file_cursor;
    int                       pass_count;
    int                       fail_count;
    int                       wd_cycles;
    logic [16:0]              lfsr;
    logic [3:0]               q_mask [$];
    bit                       q_rand [$];
    int                       q_hold [$];
    int                       q_rel [$];
    int                       q_cursor [$];

    menu_top UUT (.*);

    menu_checker u_checker (.*);

    // Taps 17 and 14.
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    // Key names joined by '+', only the first letter of each counts.
    function automatic logic [3:0] parse_keys(input string name);
        logic [3:0] m;
        m = 4'b0000;
        for (int i = 0; i < name.len(); i++) begin
            if (i == 0 || name.getc(i - 1) == "+") begin
                case (name.getc(i))
                    "u": m[3] = 1'b1;
                    "d": m[2] = 1'b1;
                    "l": m[1] = 1'b1;
                    "r": m[0] = 1'b1;
                    default: m = m;
                endcase
            end
        end
        return m;
    endfunction

    task automatic load_stim();
        int    fd;
        int    n;
        int    hold;
        int    rel;
        int    cur;
        string line;
        string name;
        fd = $fopen("menu_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file menu_stim.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n    = 0;
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %d %d %d", name, hold, rel, cur);
            end
            if (n == 4) begin
                q_rand.push_back(name == "rand");
                q_mask.push_back(parse_keys(name));
                q_hold.push_back(hold);
                q_rel.push_back(rel);
                q_cursor.push_back(cur);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_line(input int idx);
        logic [3:0] mask;
        int         hold;
        int         bits;
        int         len;
        mask = q_mask[idx];
        hold = q_hold[idx];
        if (q_rand[idx]) begin
            take_bits(4, bits);
            mask = 4'(bits);
            take_bits(2, bits);
            hold = bits + 1;
        end
        len = hold + q_rel[idx];
        for (int c = 0; c < len; c++) begin
            @(negedge clk);
            {key_up, key_down, key_left, key_right} = (c < hold) ? mask : 4'b0000;
            test_num    = idx + 1;
            file_cursor = q_cursor[idx];
            test_done   = (c == len - 1);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Sweep the text read port, one row per cycle.
    always @(negedge clk) begin
        row_sel <= (row_sel == 4'd11) ? 4'd0 : row_sel + 4'd1;
    end

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", wd_cycles);
        $display("Errors found");
        $finish;
    end

    initial begin
        int total;
        rst         = 1'b1;
        key_up      = 1'b0;
        key_down    = 1'b0;
        key_left    = 1'b0;
        key_right   = 1'b0;
        row_sel     = 4'd0;
        test_done   = 1'b0;
        test_num    = 0;
        file_cursor = -1;
        wd_cycles   = 0;
        lfsr        = 17'd89930;
        load_stim();
        // Random lines hold for at most 4 cycles.
        total = 100;
        foreach (q_hold[i]) total += (q_rand[i] ? 4 : q_hold[i]) + q_rel[i];
        wd_cycles = total;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        foreach (q_hold[i]) run_line(i);
        @(negedge clk);
        test_done = 1'b0;
        repeat (2) @(negedge clk);
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0 && pass_count == q_hold.size()) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
